// File: source/btLink_cfg.svh
`ifndef BT_LINK_CFG_SVH
`define BT_LINK_CFG_SVH

// command buffer, in characters
`define BT_CMD_DEPTH 32
// index into the command buffer, the write pointer has one bit more
`define BT_CMD_IDX_WIDTH 5

// reply bytes kept, shown on ep21 to ep30
`define BT_RESP_BYTES 20
// saturating reply count, also the status field width
`define BT_RESP_CNT_WIDTH 5

// bit period, spacing limit and bit timers
`define BT_CPD_WIDTH 10

`endif

// File: source/btLinkPkg.sv
package btLinkPkg;

	// one serial character, also the buffer element
	typedef logic [7:0] charT;

	// ==============================
	// bit positions in the host control word (ep02)
	typedef enum int unsigned {
		clearCommand  = 0,
		writePair     = 1,
		sendCommand   = 2,
		clearResponse = 3
	} hostCtrlBit;

	// ==============================
	// field start positions in the status word (ep20)
	typedef enum int unsigned {
		respCount  = 0, // 5 bits
		cmdBusy    = 5,
		frameError = 6,
		btState    = 7,
		cmdLength  = 8  // 8 bits
	} statusField;

endpackage

// File: source/uartTransmitter.sv
`timescale 1ns/100ps
`include "btLink_cfg.svh"

module uartTransmitter (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     start,
	input  btLinkPkg::charT          txData,
	input  logic [`BT_CPD_WIDTH-1:0] cyclesPerBit,
	output logic                     txLine,
	output logic                     txBusy,
	output logic                     txDone
);

	logic [8:0]               shiftReg;  // data bits, stop bit on top
	logic [3:0]               bitIndex;  // 0 start, 1-8 data, 9 stop
	logic [`BT_CPD_WIDTH-1:0] bitTimer;
	logic [`BT_CPD_WIDTH-1:0] bitPeriod;
	logic                     bitEnd;

	assign bitEnd = (bitTimer == bitPeriod - 1'b1);
	assign txDone = txBusy && bitEnd && (bitIndex == 4'd9); // last stop bit cycle

	// frame payload, frozen until the next start
	always_ff @(posedge clock) begin
		if (start && !txBusy) begin
			shiftReg  <= {1'b1, txData};
			bitPeriod <= cyclesPerBit;
		end else if (txBusy && bitEnd) begin
			shiftReg <= {1'b1, shiftReg[8:1]};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			txLine   <= 1'b1;
			txBusy   <= 1'b0;
			bitIndex <= '0;
			bitTimer <= '0;
		end else if (!txBusy) begin
			bitIndex <= '0;
			bitTimer <= '0;
			if (start) begin
				txBusy <= 1'b1;
				txLine <= 1'b0; // start bit
			end
		end else if (bitEnd) begin
			bitTimer <= '0;
			if (bitIndex == 4'd9) begin
				txBusy <= 1'b0;
			end else begin
				txLine   <= shiftReg[0]; // lsb first, then stop
				bitIndex <= bitIndex + 1'b1;
			end
		end else begin
			bitTimer <= bitTimer + 1'b1;
		end
	end

endmodule

// File: source/uartReceiver.sv
`timescale 1ns/100ps
`include "btLink_cfg.svh"

module uartReceiver (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     rxLine,
	input  logic [`BT_CPD_WIDTH-1:0] cyclesPerBit,
	output btLinkPkg::charT          rxData,
	output logic                     rxValid,
	output logic                     rxFrameError
);

	localparam logic [1:0] stateIdle  = 2'd0;
	localparam logic [1:0] stateStart = 2'd1;
	localparam logic [1:0] stateData  = 2'd2;
	localparam logic [1:0] stateStop  = 2'd3;

	logic                     syncMeta;
	logic                     syncLine;
	logic                     linePrev;
	logic [1:0]               state;
	logic [2:0]               bitCount;
	logic [`BT_CPD_WIDTH-1:0] bitTimer;
	logic [`BT_CPD_WIDTH-1:0] bitPeriod;
	logic                     midStart;
	logic                     bitEnd;
	btLinkPkg::charT          shiftReg;

	assign midStart = (bitTimer == (bitPeriod >> 1));
	assign bitEnd   = (bitTimer == bitPeriod - 1'b1);
	assign rxData   = shiftReg;

	always_ff @(posedge clock) begin
		if (reset) begin
			syncMeta <= 1'b1;
			syncLine <= 1'b1;
			linePrev <= 1'b1;
		end else begin
			syncMeta <= rxLine;
			syncLine <= syncMeta;
			linePrev <= syncLine;
		end
	end

	// bit period follows the input only between frames
	always_ff @(posedge clock) begin
		if (state == stateIdle) begin
			bitPeriod <= cyclesPerBit;
		end
		if (state == stateData && bitEnd) begin
			shiftReg <= {syncLine, shiftReg[7:1]}; // lsb arrives first
		end
	end

	// ==============================
	// frame FSM, timer runs from mid start bit
	always_ff @(posedge clock) begin
		if (reset) begin
			state        <= stateIdle;
			bitCount     <= '0;
			bitTimer     <= '0;
			rxValid      <= 1'b0;
			rxFrameError <= 1'b0;
		end else begin
			rxValid      <= 1'b0;
			rxFrameError <= 1'b0;
			bitTimer     <= bitTimer + 1'b1;
			case (state)
				stateIdle: begin
					bitTimer <= '0;
					bitCount <= '0;
					if (linePrev && !syncLine) state <= stateStart; // falling edge
				end
				stateStart: if (midStart) begin
					bitTimer <= '0;
					state    <= syncLine ? stateIdle : stateData; // glitch rejected
				end
				stateData: if (bitEnd) begin
					bitTimer <= '0;
					bitCount <= bitCount + 1'b1;
					if (bitCount == 3'd7) state <= stateStop;
				end
				stateStop: if (bitEnd) begin
					rxValid      <= syncLine;
					rxFrameError <= !syncLine;
					state        <= stateIdle;
				end
			endcase
		end
	end

endmodule

// File: source/commandSequencer.sv
`timescale 1ns/100ps
`include "btLink_cfg.svh"

module commandSequencer (
	input  logic                     clock,
	input  logic                     reset,
	input  logic [15:0]              hostData,
	input  logic [15:0]              hostControl,
	input  logic [`BT_CPD_WIDTH-1:0] spacingLimit,
	input  logic [`BT_CPD_WIDTH-1:0] cyclesPerBit,
	input  logic                     txBusy,
	input  logic                     txDone,
	output logic                     txStart,
	output btLinkPkg::charT          txData,
	output logic                     respClear,
	output logic                     cmdBusy,
	output logic [7:0]               cmdLength
);

	localparam logic [1:0] seqIdle     = 2'd0;
	localparam logic [1:0] seqLaunch   = 2'd1;
	localparam logic [1:0] seqWaitDone = 2'd2;
	localparam logic [1:0] seqSpacing  = 2'd3;

	logic [btLinkPkg::clearResponse:0] ctrlNow;
	logic [btLinkPkg::clearResponse:0] ctrlPrev;
	logic [btLinkPkg::clearResponse:0] ctrlRise;

	btLinkPkg::charT           cmdMem [`BT_CMD_DEPTH];
	logic [`BT_CMD_IDX_WIDTH:0] writePtr;
	logic [`BT_CMD_IDX_WIDTH:0] readIdx;
	logic                       pairWrite;
	logic [1:0]                 state;
	logic [`BT_CPD_WIDTH-1:0]   spaceTimer;
	logic [`BT_CPD_WIDTH-1:0]   spaceBits;

	assign ctrlRise  = ctrlNow & ~ctrlPrev;
	assign pairWrite = ctrlRise[btLinkPkg::writePair] && !ctrlRise[btLinkPkg::clearCommand]
		&& (writePtr <= `BT_CMD_DEPTH - 2); // full buffer drops the pair
	assign cmdLength = 8'(writePtr);
	assign txStart   = (state == seqLaunch) && !txBusy;
	assign txData    = cmdMem[readIdx[`BT_CMD_IDX_WIDTH-1:0]];

	always_ff @(posedge clock) begin
		if (reset) begin
			ctrlNow   <= '0;
			ctrlPrev  <= '0;
			respClear <= 1'b0;
			writePtr  <= '0;
		end else begin
			ctrlNow   <= hostControl[btLinkPkg::clearResponse:0];
			ctrlPrev  <= ctrlNow;
			respClear <= ctrlRise[btLinkPkg::clearResponse];
			if (ctrlRise[btLinkPkg::clearCommand]) writePtr <= '0;
			else if (pairWrite) writePtr <= writePtr + 2'd2;
		end
	end

	// high byte goes out first
	always_ff @(posedge clock) begin
		if (pairWrite) begin
			cmdMem[writePtr[`BT_CMD_IDX_WIDTH-1:0]]        <= hostData[15:8];
			cmdMem[writePtr[`BT_CMD_IDX_WIDTH-1:0] + 1'b1] <= hostData[7:0];
		end
	end

	// ==============================
	// send FSM with inter-byte spacing
	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= seqIdle;
			readIdx    <= '0;
			cmdBusy    <= 1'b0;
			spaceTimer <= '0;
			spaceBits  <= '0;
		end else begin
			case (state)
				seqIdle: begin
					readIdx <= '0;
					if (ctrlRise[btLinkPkg::sendCommand] && writePtr != '0) begin
						state   <= seqLaunch;
						cmdBusy <= 1'b1;
					end
				end
				seqLaunch: if (!txBusy) state <= seqWaitDone;
				seqWaitDone: if (txDone) begin
					state      <= seqSpacing;
					readIdx    <= readIdx + 1'b1;
					spaceTimer <= '0;
					spaceBits  <= '0;
				end
				seqSpacing: begin
					if (spaceBits == spacingLimit) begin
						if (readIdx >= writePtr) begin // also ends early after a clear
							state   <= seqIdle;
							cmdBusy <= 1'b0;
						end else begin
							state <= seqLaunch;
						end
					end else if (spaceTimer == cyclesPerBit - 1'b1) begin
						spaceTimer <= '0;
						spaceBits  <= spaceBits + 1'b1;
					end else begin
						spaceTimer <= spaceTimer + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

// File: source/responseCollector.sv
`timescale 1ns/100ps
`include "btLink_cfg.svh"

module responseCollector (
	input  logic            clock,
	input  logic            reset,
	input  btLinkPkg::charT rxData,
	input  logic            rxValid,
	input  logic            rxFrameError,
	input  logic            respClear,
	input  logic            cmdBusy,
	input  logic [7:0]      cmdLength,
	input  logic            btState,
	output logic [15:0]     statusWord,
	output logic [15:0]     respWord0,
	output logic [15:0]     respWord1,
	output logic [15:0]     respWord2,
	output logic [15:0]     respWord3,
	output logic [15:0]     respWord4,
	output logic [15:0]     respWord5,
	output logic [15:0]     respWord6,
	output logic [15:0]     respWord7,
	output logic [15:0]     respWord8,
	output logic [15:0]     respWord9
);

	btLinkPkg::charT               respMem   [`BT_RESP_BYTES];
	btLinkPkg::charT               shownByte [`BT_RESP_BYTES];
	logic [`BT_RESP_CNT_WIDTH-1:0] respCount;
	logic                          frameErrorFlag;
	logic                          storeByte;

	assign storeByte = rxValid && (respCount < `BT_RESP_BYTES); // full buffer drops bytes

	always_ff @(posedge clock) begin
		if (storeByte) respMem[respCount] <= rxData;
	end

	always_ff @(posedge clock) begin
		if (reset || respClear) begin
			respCount      <= '0;
			frameErrorFlag <= 1'b0;
		end else begin
			if (storeByte) respCount <= respCount + 1'b1;
			if (rxFrameError) frameErrorFlag <= 1'b1; // sticky until cleared
		end
	end

	// ==============================
	// ep20 status and packed reply words
	always_comb begin
		statusWord = '0;
		statusWord[btLinkPkg::respCount +: `BT_RESP_CNT_WIDTH] = respCount;
		statusWord[btLinkPkg::cmdBusy]                       = cmdBusy;
		statusWord[btLinkPkg::frameError]                    = frameErrorFlag;
		statusWord[btLinkPkg::btState]                       = btState;
		statusWord[btLinkPkg::cmdLength +: 8]                = cmdLength;
		for (int i = 0; i < `BT_RESP_BYTES; i++) begin
			shownByte[i] = (i < respCount) ? respMem[i] : '0; // unreceived read zero
		end
	end

	assign respWord0 = {shownByte[0],  shownByte[1]};
	assign respWord1 = {shownByte[2],  shownByte[3]};
	assign respWord2 = {shownByte[4],  shownByte[5]};
	assign respWord3 = {shownByte[6],  shownByte[7]};
	assign respWord4 = {shownByte[8],  shownByte[9]};
	assign respWord5 = {shownByte[10], shownByte[11]};
	assign respWord6 = {shownByte[12], shownByte[13]};
	assign respWord7 = {shownByte[14], shownByte[15]};
	assign respWord8 = {shownByte[16], shownByte[17]};
	assign respWord9 = {shownByte[18], shownByte[19]};

endmodule

// File: source/btLink.sv
`timescale 1ns/100ps
`include "btLink_cfg.svh"

module btLink (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     btState,
	input  logic                     fpgaRxd,
	input  logic [`BT_CPD_WIDTH-1:0] uartCpd,
	input  logic [`BT_CPD_WIDTH-1:0] uartSpacingLimit,
	input  logic [15:0]              ep01wireIn,
	input  logic [15:0]              ep02wireIn,
	output logic                     fpgaTxd,
	output logic [15:0]              ep20wireOut,
	output logic [15:0]              ep21wireOut,
	output logic [15:0]              ep22wireOut,
	output logic [15:0]              ep23wireOut,
	output logic [15:0]              ep24wireOut,
	output logic [15:0]              ep25wireOut,
	output logic [15:0]              ep26wireOut,
	output logic [15:0]              ep27wireOut,
	output logic [15:0]              ep28wireOut,
	output logic [15:0]              ep29wireOut,
	output logic [15:0]              ep30wireOut
);

	logic            txStart;
	btLinkPkg::charT txData;
	logic            txBusy;
	logic            txDone;
	btLinkPkg::charT rxData;
	logic            rxValid;
	logic            rxFrameError;
	logic            respClear;
	logic            cmdBusy;
	logic [7:0]      cmdLength;

	// ==============================
	// host side to module
	commandSequencer sequencer0 (
		.clock(clock), .reset(reset),
		.hostData(ep01wireIn), .hostControl(ep02wireIn),
		.spacingLimit(uartSpacingLimit), .cyclesPerBit(uartCpd),
		.txBusy(txBusy), .txDone(txDone),
		.txStart(txStart), .txData(txData), .respClear(respClear),
		.cmdBusy(cmdBusy), .cmdLength(cmdLength)
	);

	uartTransmitter transmitter0 (
		.clock(clock), .reset(reset), .start(txStart), .txData(txData),
		.cyclesPerBit(uartCpd), .txLine(fpgaTxd), .txBusy(txBusy), .txDone(txDone)
	);

	// ==============================
	// module replies back to host
	uartReceiver receiver0 (
		.clock(clock), .reset(reset), .rxLine(fpgaRxd), .cyclesPerBit(uartCpd),
		.rxData(rxData), .rxValid(rxValid), .rxFrameError(rxFrameError)
	);

	responseCollector collector0 (
		.clock(clock), .reset(reset),
		.rxData(rxData), .rxValid(rxValid), .rxFrameError(rxFrameError),
		.respClear(respClear), .cmdBusy(cmdBusy), .cmdLength(cmdLength),
		.btState(btState), .statusWord(ep20wireOut),
		.respWord0(ep21wireOut), .respWord1(ep22wireOut), .respWord2(ep23wireOut),
		.respWord3(ep24wireOut), .respWord4(ep25wireOut), .respWord5(ep26wireOut),
		.respWord6(ep27wireOut), .respWord7(ep28wireOut), .respWord8(ep29wireOut),
		.respWord9(ep30wireOut)
	);

endmodule

// File: sim/tbBtLink.sv
`timescale 1ns/100ps
`include "btLink_cfg.svh"

module tbBtLink;

	typedef btLinkPkg::charT charQueue [$];

	logic                     clock;
	logic                     reset;
	logic                     btState;
	logic                     fpgaRxd;
	logic [`BT_CPD_WIDTH-1:0] uartCpd;
	logic [`BT_CPD_WIDTH-1:0] uartSpacingLimit;
	logic [15:0]              ep01wireIn;
	logic [15:0]              ep02wireIn;
	logic                     fpgaTxd;
	logic [15:0]              epOut [11]; // ep20 to ep30

	logic [15:0] hostWords [$];
	charQueue    expectedTx;
	charQueue    sentTx;
	int          sentGaps [$];
	charQueue    replies;
	int          errorCount;
	string       testName;

	int              monPhase;
	int              monTimer;
	int              monBit;
	int              idleCount;
	int              frameGap;
	btLinkPkg::charT monValue;

	btLink dut0 (
		.clock(clock), .reset(reset), .btState(btState), .fpgaRxd(fpgaRxd),
		.uartCpd(uartCpd), .uartSpacingLimit(uartSpacingLimit),
		.ep01wireIn(ep01wireIn), .ep02wireIn(ep02wireIn), .fpgaTxd(fpgaTxd),
		.ep20wireOut(epOut[0]), .ep21wireOut(epOut[1]), .ep22wireOut(epOut[2]),
		.ep23wireOut(epOut[3]), .ep24wireOut(epOut[4]), .ep25wireOut(epOut[5]),
		.ep26wireOut(epOut[6]), .ep27wireOut(epOut[7]), .ep28wireOut(epOut[8]),
		.ep29wireOut(epOut[9]), .ep30wireOut(epOut[10])
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic abortRun(input string reason);
		errorCount++;
		$display("%s", reason);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			abortRun($sformatf("error %s %s: expected 0x%0h, actual 0x%0h",
				testName, what, expected, actual));
		end
	endtask

	// expected serial stream, high byte of each write first, full buffer drops pairs
	function automatic charQueue commandBytes(input logic [15:0] words [$]);
		charQueue result;
		foreach (words[i]) begin
			if (result.size() + 2 <= `BT_CMD_DEPTH) begin
				result.push_back(words[i][15:8]);
				result.push_back(words[i][7:0]);
			end
		end
		return result;
	endfunction

	function automatic int statusBits(input int pos, input int width);
		return (int'(epOut[0]) >> pos) & ((1 << width) - 1);
	endfunction

	// ==============================
	// fpgaTxd monitor, samples mid-bit
	always @(negedge clock) begin
		if (reset) begin
			monPhase  = 0;
			idleCount = 0;
		end else if (monPhase == 0) begin
			if (fpgaTxd) idleCount++;
			else begin
				monPhase = 1;
				monTimer = 0;
				monBit   = 0;
				frameGap = idleCount;
			end
		end else begin
			monTimer++;
			if (monTimer == monBit * int'(uartCpd) + int'(uartCpd) / 2) begin
				if (monBit >= 1 && monBit <= 8) monValue[monBit - 1] = fpgaTxd;
				if (monBit < 9) monBit++;
				else if (fpgaTxd) begin
					sentTx.push_back(monValue);
					sentGaps.push_back(frameGap);
					idleCount = int'(uartCpd) / 2 - int'(uartCpd); // rest of stop bit
					monPhase  = 0;
				end else begin
					abortRun("a frame on fpgaTxd ended with a low stop bit");
				end
			end
		end
	end

	// compare against the reference stream
	always @(negedge clock) begin
		int gap;
		if (sentTx.size() > 0) begin
			gap = sentGaps.pop_front();
			if (expectedTx.size() == 0) begin
				abortRun($sformatf("byte 0x%0h was sent on fpgaTxd but none was expected",
					sentTx[0]));
			end else begin
				checkValue("tx byte", expectedTx.pop_front(), sentTx.pop_front());
				checkValue("cmdBusy while sending", 1, statusBits(btLinkPkg::cmdBusy, 1));
				// one bit period of slack
				checkValue("tx gap ok", 1,
					gap >= (int'(uartSpacingLimit) - 1) * int'(uartCpd));
			end
		end
	end

	// ==============================
	task automatic waitStatus(input int pos, input int width, input int value,
		input int limit, input string what);
		int cycles;
		cycles = 0;
		while (statusBits(pos, width) != value) begin
			if (cycles >= limit) abortRun($sformatf("timed out waiting for %s", what));
			else begin
				@(negedge clock);
				cycles++;
			end
		end
	endtask

	task automatic pickTiming();
		uartCpd          = `BT_CPD_WIDTH'(8 + $urandom % 9);
		uartSpacingLimit = `BT_CPD_WIDTH'($urandom % 4);
		@(negedge clock);
	endtask

	task automatic pulseControl(input btLinkPkg::hostCtrlBit which);
		ep02wireIn[which] = 1'b1;
		repeat (2) @(negedge clock);
		ep02wireIn[which] = 1'b0;
		repeat (2) @(negedge clock);
	endtask

	task automatic writePairWord(input logic [15:0] word);
		ep01wireIn = word;
		hostWords.push_back(word);
		pulseControl(btLinkPkg::writePair);
	endtask

	task automatic sendFrame(input btLinkPkg::charT value, input logic stopLevel);
		fpgaRxd = 1'b0;
		repeat (uartCpd) @(negedge clock);
		for (int i = 0; i < 8; i++) begin
			fpgaRxd = value[i]; // lsb first
			repeat (uartCpd) @(negedge clock);
		end
		fpgaRxd = stopLevel;
		repeat (uartCpd) @(negedge clock);
		fpgaRxd = 1'b1;
		repeat (2 * uartCpd) @(negedge clock);
	endtask

	task automatic sendReply(input btLinkPkg::charT value);
		sendFrame(value, 1'b1);
		replies.push_back(value);
		if (replies.size() <= `BT_RESP_BYTES) begin
			waitStatus(btLinkPkg::respCount, `BT_RESP_CNT_WIDTH, replies.size(),
				4 * int'(uartCpd) + 20, "the reply count");
		end
	endtask

	task automatic checkResponses();
		int          shown;
		logic [15:0] expectedWord;
		shown = (replies.size() < `BT_RESP_BYTES) ? replies.size() : `BT_RESP_BYTES;
		checkValue("reply count", shown, statusBits(btLinkPkg::respCount, `BT_RESP_CNT_WIDTH));
		for (int k = 0; k < `BT_RESP_BYTES / 2; k++) begin
			expectedWord = '0;
			if (2 * k < shown) expectedWord[15:8] = replies[2 * k];
			if (2 * k + 1 < shown) expectedWord[7:0] = replies[2 * k + 1];
			checkValue($sformatf("ep%0d", 21 + k), expectedWord, epOut[k + 1]);
		end
	endtask

	// ==============================
	initial begin
		charQueue expectedCmd;
		int       limit;
		void'($urandom(32'h6f35_3ddb));
		errorCount       = 0;
		testName         = "reset";
		reset            = 1'b1;
		btState          = 1'($urandom);
		fpgaRxd          = 1'b1;
		uartCpd          = `BT_CPD_WIDTH'(8);
		uartSpacingLimit = '0;
		ep01wireIn       = '0;
		ep02wireIn       = '0;
		repeat (16) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		checkValue("fpgaTxd", 1, fpgaTxd);
		for (int i = 0; i < 2; i++) begin
			checkValue("ep20", int'(btState) << btLinkPkg::btState, epOut[0]);
			for (int k = 1; k < 11; k++) checkValue($sformatf("ep%0d", 20 + k), 0, epOut[k]);
			btState = ~btState;
			@(negedge clock);
		end

		testName = "command";
		pickTiming();
		uartSpacingLimit = `BT_CPD_WIDTH'(2 + $urandom % 2); // gap visible beyond the slack
		writePairWord("AT");
		writePairWord("+N");
		writePairWord("AM");
		writePairWord("E=");
		writePairWord("OP");
		expectedCmd = commandBytes(hostWords);
		checkValue("cmdLength", expectedCmd.size(), statusBits(btLinkPkg::cmdLength, 8));
		expectedTx = expectedCmd;
		pulseControl(btLinkPkg::sendCommand);
		waitStatus(btLinkPkg::cmdBusy, 1, 1, 20, "cmdBusy to rise");
		limit = expectedCmd.size() * (12 + int'(uartSpacingLimit)) * int'(uartCpd) + 100;
		waitStatus(btLinkPkg::cmdBusy, 1, 0, limit, "cmdBusy to clear");
		checkValue("bytes left unsent", 0, expectedTx.size());

		testName = "reply";
		pickTiming();
		pulseControl(btLinkPkg::clearResponse);
		replies.delete();
		sendReply("O");
		sendReply("K");
		repeat (4) sendReply(8'($urandom));
		checkResponses();

		testName = "overflow";
		while (replies.size() < `BT_RESP_BYTES + 3) sendReply(8'($urandom));
		checkResponses();
		pulseControl(btLinkPkg::clearResponse);
		replies.delete();
		checkResponses();

		testName = "frame error";
		pickTiming();
		sendReply(8'($urandom));
		sendFrame(8'($urandom), 1'b0);
		waitStatus(btLinkPkg::frameError, 1, 1, 4 * int'(uartCpd), "the frame error flag");
		checkResponses(); // count unchanged
		pulseControl(btLinkPkg::clearResponse);
		replies.delete();
		checkValue("frameError", 0, statusBits(btLinkPkg::frameError, 1));
		checkResponses();
		repeat ($urandom % 8) @(negedge clock);
		pulseControl(btLinkPkg::clearCommand);
		hostWords.delete();
		expectedTx = commandBytes(hostWords);
		checkValue("cmdLength", 0, statusBits(btLinkPkg::cmdLength, 8));
		pulseControl(btLinkPkg::sendCommand);
		// empty buffer, line stays idle
		for (int i = 0; i < 20 * int'(uartCpd); i++) begin
			@(negedge clock);
			checkValue("fpgaTxd idle", 1, fpgaTxd);
			checkValue("cmdBusy", 0, statusBits(btLinkPkg::cmdBusy, 1));
		end

		if (errorCount == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "checks failed");
		end
	end

endmodule

// File: src.f
+incdir+source
source/btLinkPkg.sv
source/uartTransmitter.sv
source/uartReceiver.sv
source/commandSequencer.sv
source/responseCollector.sv
source/btLink.sv
sim/tbBtLink.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tbBtLink
RTL_TOP    ?= btLink
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

lint-rtl:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
